//--- design/rt_pkg.sv
package rt_pkg;

  // q8.8 signed fixed point.
  localparam int fix_w  = 16;
  localparam int frac_w = 8;
  localparam int num_w  = 32;         // t numerator and denominator.
  localparam int acc_w  = num_w + 2;  // room for three summed products.

  // leaf list bookkeeping.
  localparam int ray_id_w = 8;
  localparam int tri_id_w = 12;
  localparam int lindex_w = 15;
  localparam int lnum_w   = 6;

  localparam int math_lat = 4;

  // one buffer entry per upstream credit.
  localparam int in_credits = 4;
  localparam int in_ptr_w   = $clog2(in_credits);
  localparam int in_cnt_w   = $clog2(in_credits + 1);

  // out_depth must cover math_lat + 1 results in flight.
  localparam int out_depth   = 8;
  localparam int out_credits = 4;
  localparam int free_w      = $clog2(out_depth + 1);
  localparam int cred_w      = $clog2(out_credits + 1);

  // packed widths.
  localparam int side_w = ray_id_w + tri_id_w + lindex_w + lnum_w;
  localparam int geo_w  = 18 * fix_w;  // origin, direction, matrix, translate.
  localparam int ent_w  = side_w + geo_w;
  localparam int sb_w   = side_w + 1;  // sideband plus last flag.
  localparam int list_w = ray_id_w + tri_id_w + 2 + 2 * num_w;
  localparam int leaf_w = ray_id_w + lindex_w + lnum_w;

  typedef logic signed [fix_w-1:0] fix_t;
  typedef logic signed [num_w-1:0] num_t;

  // intake buffer condition.
  typedef enum logic [1:0] {
    buf_empty,
    buf_partial,
    buf_full
  } buf_state_e;

endpackage

//--- design/ray_intake.sv
module ray_intake
  import rt_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [ray_id_w-1:0] in_ray_id,
  input  logic [tri_id_w-1:0] in_tri_id,
  input  logic [lindex_w-1:0] in_lindex,
  input  logic [lnum_w-1:0]   in_lnum_left,
  input  fix_t                in_org_x, in_org_y, in_org_z,
  input  fix_t                in_dir_x, in_dir_y, in_dir_z,
  input  fix_t                in_m00, in_m01, in_m02,
  input  fix_t                in_m10, in_m11, in_m12,
  input  fix_t                in_m20, in_m21, in_m22,
  input  fix_t                in_tr_x, in_tr_y, in_tr_z,
  input  logic                res_valid,
  input  logic [free_w-1:0]   list_free,
  input  logic [free_w-1:0]   leaf_free,
  output logic                in_credit,
  output logic                iss_valid,
  output logic [ray_id_w-1:0] iss_ray_id,
  output logic [tri_id_w-1:0] iss_tri_id,
  output logic [lindex_w-1:0] iss_lindex,
  output logic [lnum_w-1:0]   iss_lnum_left,
  output logic                iss_last,
  output fix_t                iss_org_x, iss_org_y, iss_org_z,
  output fix_t                iss_dir_x, iss_dir_y, iss_dir_z,
  output fix_t                iss_m00, iss_m01, iss_m02,
  output fix_t                iss_m10, iss_m11, iss_m12,
  output fix_t                iss_m20, iss_m21, iss_m22,
  output fix_t                iss_tr_x, iss_tr_y, iss_tr_z
);

  logic [ent_w-1:0]    buf_mem [in_credits];
  logic [in_ptr_w-1:0] wr_ptr, rd_ptr;
  logic [in_cnt_w-1:0] buf_cnt, buf_cnt_nxt;
  buf_state_e          buf_state;
  logic [free_w-1:0]   inflight;  // issued, not yet in the output fifos.
  logic [free_w-1:0]   min_free;
  logic                issue;
  logic [ray_id_w-1:0] h_ray_id;
  logic [tri_id_w-1:0] h_tri_id;
  logic [lindex_w-1:0] h_lindex;
  logic [lnum_w-1:0]   h_lnum_left;
  logic [geo_w-1:0]    h_geo;

  assign {h_ray_id, h_tri_id, h_lindex, h_lnum_left, h_geo} = buf_mem[rd_ptr];

  // every item in flight may land in both fifos.
  assign min_free    = (list_free < leaf_free) ? list_free : leaf_free;
  assign issue       = (buf_state != buf_empty) && (inflight < min_free);
  assign in_credit   = iss_valid;  // entry freed on issue.
  assign buf_cnt_nxt = buf_cnt + in_cnt_w'(in_valid) - in_cnt_w'(issue);

  always_ff @(posedge clk) begin
    if (in_valid) begin
      buf_mem[wr_ptr] <= {in_ray_id, in_tri_id, in_lindex, in_lnum_left,
                          in_org_x, in_org_y, in_org_z, in_dir_x, in_dir_y, in_dir_z,
                          in_m00, in_m01, in_m02, in_m10, in_m11, in_m12,
                          in_m20, in_m21, in_m22, in_tr_x, in_tr_y, in_tr_z};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      buf_cnt   <= '0;
      buf_state <= buf_empty;
      inflight  <= '0;
      iss_valid <= 1'b0;
    end else begin
      if (in_valid) wr_ptr <= (wr_ptr == in_ptr_w'(in_credits - 1)) ? '0 : wr_ptr + 1'b1;
      if (issue) rd_ptr <= (rd_ptr == in_ptr_w'(in_credits - 1)) ? '0 : rd_ptr + 1'b1;
      buf_cnt <= buf_cnt_nxt;
      if (buf_cnt_nxt == '0) buf_state <= buf_empty;
      else if (buf_cnt_nxt == in_cnt_w'(in_credits)) buf_state <= buf_full;
      else buf_state <= buf_partial;
      inflight  <= inflight + free_w'(issue) - free_w'(res_valid);
      iss_valid <= issue;
    end
  end

  // bookkeeping step on the way out.
  always_ff @(posedge clk) begin
    if (issue) begin
      iss_ray_id    <= h_ray_id;
      iss_tri_id    <= h_tri_id;
      iss_lindex    <= h_lindex + 1'b1;
      iss_lnum_left <= h_lnum_left - 1'b1;
      iss_last      <= (h_lnum_left == '0);
      {iss_org_x, iss_org_y, iss_org_z, iss_dir_x, iss_dir_y, iss_dir_z,
       iss_m00, iss_m01, iss_m02, iss_m10, iss_m11, iss_m12,
       iss_m20, iss_m21, iss_m22, iss_tr_x, iss_tr_y, iss_tr_z} <= h_geo;
    end
  end

endmodule

//--- design/int_math.sv
module int_math
  import rt_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                iss_valid,
  input  logic [ray_id_w-1:0] iss_ray_id,
  input  logic [tri_id_w-1:0] iss_tri_id,
  input  logic [lindex_w-1:0] iss_lindex,
  input  logic [lnum_w-1:0]   iss_lnum_left,
  input  logic                iss_last,
  input  fix_t                iss_org_x, iss_org_y, iss_org_z,
  input  fix_t                iss_dir_x, iss_dir_y, iss_dir_z,
  input  fix_t                iss_m00, iss_m01, iss_m02,
  input  fix_t                iss_m10, iss_m11, iss_m12,
  input  fix_t                iss_m20, iss_m21, iss_m22,
  input  fix_t                iss_tr_x, iss_tr_y, iss_tr_z,
  output logic                res_valid,
  output logic [ray_id_w-1:0] res_ray_id,
  output logic [tri_id_w-1:0] res_tri_id,
  output logic [lindex_w-1:0] res_lindex,
  output logic [lnum_w-1:0]   res_lnum_left,
  output logic                res_last,
  output logic                res_hit,
  output num_t                res_t_num,
  output num_t                res_denom
);

  logic [math_lat-1:0]     vld_pipe;
  logic [sb_w-1:0]         sb_pipe [math_lat];
  logic signed [acc_w-1:0] po_x, po_y, po_z, pd_x, pd_y, pd_z;
  fix_t                    tr1_x, tr1_y, tr1_z;
  logic signed [acc_w-1:0] to_x, to_y, to_z;
  fix_t                    o_x, o_y, o_z, d_x, d_y, d_z;
  fix_t                    s2;
  num_t                    t3;
  logic signed [num_w:0]   u3, v3;
  fix_t                    s3;
  logic signed [acc_w-1:0] uv_sum, one_s;
  logic                    pos_ok, neg_ok;

  // valid and sideband ride alongside the math.
  always_ff @(posedge clk) begin
    if (!rst_n) vld_pipe <= '0;
    else vld_pipe <= {vld_pipe[math_lat-2:0], iss_valid};
  end

  always_ff @(posedge clk) begin
    sb_pipe[0] <= {iss_ray_id, iss_tri_id, iss_lindex, iss_lnum_left, iss_last};
    for (int i = 1; i < math_lat; i++) sb_pipe[i] <= sb_pipe[i-1];
  end

  assign res_valid = vld_pipe[math_lat-1];
  assign {res_ray_id, res_tri_id, res_lindex, res_lnum_left, res_last} = sb_pipe[math_lat-1];

  // stage one, matrix products.
  always_ff @(posedge clk) begin
    po_x  <= iss_m00 * iss_org_x + iss_m01 * iss_org_y + iss_m02 * iss_org_z;
    po_y  <= iss_m10 * iss_org_x + iss_m11 * iss_org_y + iss_m12 * iss_org_z;
    po_z  <= iss_m20 * iss_org_x + iss_m21 * iss_org_y + iss_m22 * iss_org_z;
    pd_x  <= iss_m00 * iss_dir_x + iss_m01 * iss_dir_y + iss_m02 * iss_dir_z;
    pd_y  <= iss_m10 * iss_dir_x + iss_m11 * iss_dir_y + iss_m12 * iss_dir_z;
    pd_z  <= iss_m20 * iss_dir_x + iss_m21 * iss_dir_y + iss_m22 * iss_dir_z;
    tr1_x <= iss_tr_x;
    tr1_y <= iss_tr_y;
    tr1_z <= iss_tr_z;
  end

  // stage two, translate and back to q8.8.
  assign to_x = po_x + (acc_w'(tr1_x) <<< frac_w);
  assign to_y = po_y + (acc_w'(tr1_y) <<< frac_w);
  assign to_z = po_z + (acc_w'(tr1_z) <<< frac_w);

  always_ff @(posedge clk) begin
    o_x <= to_x[frac_w +: fix_w];
    o_y <= to_y[frac_w +: fix_w];
    o_z <= to_z[frac_w +: fix_w];
    d_x <= pd_x[frac_w +: fix_w];
    d_y <= pd_y[frac_w +: fix_w];
    d_z <= pd_z[frac_w +: fix_w];
  end

  // stage three, numerators scaled by s.
  assign s2 = -d_z;

  always_ff @(posedge clk) begin
    t3 <= num_t'(o_z);  // t*s is just the origin z.
    u3 <= o_x * s2 + o_z * d_x;
    v3 <= o_y * s2 + o_z * d_y;
    s3 <= s2;
  end

  // stage four, sign and bound tests.
  assign uv_sum = u3 + v3;
  assign one_s  = acc_w'(s3) <<< frac_w;  // s in the q16.16 scale of u*s.
  assign pos_ok = (s3 > 0) && (t3 > 0) && (u3 >= 0) && (v3 >= 0) && (uv_sum <= one_s);
  assign neg_ok = (s3 < 0) && (t3 < 0) && (u3 <= 0) && (v3 <= 0) && (uv_sum >= one_s);

  always_ff @(posedge clk) begin
    res_hit   <= pos_ok || neg_ok;
    res_t_num <= t3;
    res_denom <= num_t'(s3);
  end

endmodule

//--- design/credit_fifo.sv
module credit_fifo
  import rt_pkg::*;
#(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  logic [WIDTH-1:0]           wr_data,
  input  logic                       credit,
  output logic [$clog2(DEPTH+1)-1:0] free,
  output logic                       out_valid,
  output logic [WIDTH-1:0]           out_data
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic [cred_w-1:0]          credits;  // held toward the receiver.

  // send whenever something is queued and the receiver has room.
  assign out_valid = (count != '0) && (credits != '0);
  assign out_data  = mem[rd_ptr];
  assign free      = ($clog2(DEPTH+1))'(DEPTH) - count;

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= cred_w'(out_credits);
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (out_valid) begin
        rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count + ($clog2(DEPTH+1))'(wr_en) - ($clog2(DEPTH+1))'(out_valid);
      credits <= credits - cred_w'(out_valid) + cred_w'(credit);  // spend and return.
    end
  end

endmodule

//--- design/result_router.sv
module result_router
  import rt_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                res_valid,
  input  logic [ray_id_w-1:0] res_ray_id,
  input  logic [tri_id_w-1:0] res_tri_id,
  input  logic [lindex_w-1:0] res_lindex,
  input  logic [lnum_w-1:0]   res_lnum_left,
  input  logic                res_last,
  input  logic                res_hit,
  input  num_t                res_t_num,
  input  num_t                res_denom,
  input  logic                list_credit,
  input  logic                leaf_credit,
  output logic [free_w-1:0]   list_free,
  output logic [free_w-1:0]   leaf_free,
  output logic                list_valid,
  output logic [ray_id_w-1:0] list_ray_id,
  output logic [tri_id_w-1:0] list_tri_id,
  output logic                list_hit,
  output logic                list_last,
  output num_t                list_t_num,
  output num_t                list_denom,
  output logic                leaf_valid,
  output logic [ray_id_w-1:0] leaf_ray_id,
  output logic [lindex_w-1:0] leaf_lindex,
  output logic [lnum_w-1:0]   leaf_lnum_left
);

  logic [list_w-1:0] list_din, list_dout;
  logic [leaf_w-1:0] leaf_din, leaf_dout;
  logic              list_wr, leaf_wr;

  // hits and list ends go to the list, everything not last fetches again.
  assign list_wr  = res_valid && (res_hit || res_last);
  assign leaf_wr  = res_valid && !res_last;
  assign list_din = {res_ray_id, res_tri_id, res_hit, res_last, res_t_num, res_denom};
  assign leaf_din = {res_ray_id, res_lindex, res_lnum_left};

  credit_fifo #(.WIDTH(list_w), .DEPTH(out_depth)) list_fifo (
    .clk, .rst_n,
    .wr_en(list_wr), .wr_data(list_din), .credit(list_credit),
    .free(list_free), .out_valid(list_valid), .out_data(list_dout)
  );

  credit_fifo #(.WIDTH(leaf_w), .DEPTH(out_depth)) leaf_fifo (
    .clk, .rst_n,
    .wr_en(leaf_wr), .wr_data(leaf_din), .credit(leaf_credit),
    .free(leaf_free), .out_valid(leaf_valid), .out_data(leaf_dout)
  );

  assign {list_ray_id, list_tri_id, list_hit, list_last, list_t_num, list_denom} = list_dout;
  assign {leaf_ray_id, leaf_lindex, leaf_lnum_left} = leaf_dout;

endmodule

//--- design/int_unit.sv
module int_unit
  import rt_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [ray_id_w-1:0] in_ray_id,
  input  logic [tri_id_w-1:0] in_tri_id,
  input  logic [lindex_w-1:0] in_lindex,
  input  logic [lnum_w-1:0]   in_lnum_left,
  input  fix_t                in_org_x, in_org_y, in_org_z,
  input  fix_t                in_dir_x, in_dir_y, in_dir_z,
  input  fix_t                in_m00, in_m01, in_m02,
  input  fix_t                in_m10, in_m11, in_m12,
  input  fix_t                in_m20, in_m21, in_m22,
  input  fix_t                in_tr_x, in_tr_y, in_tr_z,
  output logic                in_credit,
  output logic                list_valid,
  output logic [ray_id_w-1:0] list_ray_id,
  output logic [tri_id_w-1:0] list_tri_id,
  output logic                list_hit,
  output logic                list_last,
  output num_t                list_t_num,
  output num_t                list_denom,
  input  logic                list_credit,
  output logic                leaf_valid,
  output logic [ray_id_w-1:0] leaf_ray_id,
  output logic [lindex_w-1:0] leaf_lindex,
  output logic [lnum_w-1:0]   leaf_lnum_left,
  input  logic                leaf_credit
);

  // intake to math.
  logic                iss_valid, iss_last;
  logic [ray_id_w-1:0] iss_ray_id;
  logic [tri_id_w-1:0] iss_tri_id;
  logic [lindex_w-1:0] iss_lindex;
  logic [lnum_w-1:0]   iss_lnum_left;
  fix_t                iss_org_x, iss_org_y, iss_org_z, iss_dir_x, iss_dir_y, iss_dir_z;
  fix_t                iss_m00, iss_m01, iss_m02, iss_m10, iss_m11, iss_m12;
  fix_t                iss_m20, iss_m21, iss_m22, iss_tr_x, iss_tr_y, iss_tr_z;

  // math to router.
  logic                res_valid, res_last, res_hit;
  logic [ray_id_w-1:0] res_ray_id;
  logic [tri_id_w-1:0] res_tri_id;
  logic [lindex_w-1:0] res_lindex;
  logic [lnum_w-1:0]   res_lnum_left;
  num_t                res_t_num, res_denom;

  // router space back to the intake.
  logic [free_w-1:0]   list_free, leaf_free;

  ray_intake    intake0 (.*);
  int_math      math0   (.*);
  result_router router0 (.*);

endmodule

//--- bench/tb_clock.sv
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam time half_period = 5ns;  // 10 ns clock.

  initial clk = 1'b0;

  always #(half_period) clk = ~clk;

endmodule

//--- include/int_ref.svh
`ifndef INT_REF_SVH
`define INT_REF_SVH

// expected hit, t numerator and denominator for one request.
function automatic void intersect_ray(input fix_t org[3], input fix_t dir[3], input fix_t m[9],
                                      input fix_t tr[3], output logic hit, output num_t t_num,
                                      output num_t denom);
  longint o_acc;
  longint d_acc;
  fix_t   o[3];
  fix_t   d[3];
  fix_t   s;
  longint t_s;
  longint u_s;
  longint v_s;
  longint uv_mag;
  longint s_mag;
  // ray into unit space with products floored to q8.8.
  for (int i = 0; i < 3; i++) begin
    o_acc = longint'(tr[i]) * 256;
    d_acc = 0;
    for (int j = 0; j < 3; j++) begin
      o_acc += longint'(m[3*i+j]) * longint'(org[j]);
      d_acc += longint'(m[3*i+j]) * longint'(dir[j]);
    end
    o[i] = fix_t'(o_acc >>> frac_w);
    d[i] = fix_t'(d_acc >>> frac_w);
  end
  s      = -d[2];
  t_s    = longint'(o[2]);  // t*s is the origin height.
  u_s    = longint'(o[0]) * longint'(s) + longint'(o[2]) * longint'(d[0]);
  v_s    = longint'(o[1]) * longint'(s) + longint'(o[2]) * longint'(d[1]);
  uv_mag = (u_s + v_s < 0) ? -(u_s + v_s) : u_s + v_s;
  s_mag  = (s < 0) ? -longint'(s) : longint'(s);
  t_num  = num_t'(o[2]);
  denom  = num_t'(s);
  // hit when t, u and v share the sign of s and u + v stays within one.
  hit    = (s != 0) && (t_s * s > 0) && (u_s * s >= 0) && (v_s * s >= 0)
           && (uv_mag <= s_mag * 256);
endfunction

// last triangle of the leaf list.
function automatic logic is_final_tri(input logic [lnum_w-1:0] lnum_left);
  return lnum_left == '0;
endfunction

// routing rule per port.
function automatic logic goes_to_list(input logic hit, input logic last);
  return hit || last;
endfunction

function automatic logic needs_fetch(input logic last);
  return !last;
endfunction

`endif

//--- bench/tb_int_unit.sv
module tb_int_unit
  import rt_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  `include "int_ref.svh"

  localparam int n_tests   = 300;
  localparam int wd_cycles = n_tests * 40 + 500;

  typedef struct packed {
    logic [ray_id_w-1:0] ray_id;
    logic [tri_id_w-1:0] tri_id;
    logic                hit;
    logic                last;
    num_t                t_num;
    num_t                denom;
  } list_exp_t;

  typedef struct packed {
    logic [ray_id_w-1:0] ray_id;
    logic [lindex_w-1:0] lindex;
    logic [lnum_w-1:0]   lnum_left;
  } leaf_exp_t;

  logic                clk;
  logic                rst_n = 1'b0;
  logic                in_valid = 1'b0;
  logic                list_credit = 1'b0;
  logic                leaf_credit = 1'b0;
  logic [ray_id_w-1:0] in_ray_id = '0;
  logic [tri_id_w-1:0] in_tri_id = '0;
  logic [lindex_w-1:0] in_lindex = '0;
  logic [lnum_w-1:0]   in_lnum_left = '0;
  fix_t                org[3] = '{default: '0};
  fix_t                dir[3] = '{default: '0};
  fix_t                m[9] = '{default: '0};
  fix_t                tr[3] = '{default: '0};
  logic                in_credit, list_valid, list_hit, list_last, leaf_valid;
  logic [ray_id_w-1:0] list_ray_id, leaf_ray_id;
  logic [tri_id_w-1:0] list_tri_id;
  logic [lindex_w-1:0] leaf_lindex;
  logic [lnum_w-1:0]   leaf_lnum_left;
  num_t                list_t_num, list_denom;

  integer    seed;
  int        sent = 0, in_back = 0;  // requests sent, input credits back.
  int        list_seen = 0, list_back = 0, leaf_seen = 0, leaf_back = 0;
  int        list_cnt = 0, leaf_cnt = 0;
  int        list_pause = 0, leaf_pause = 0;
  logic      started = 1'b0;
  list_exp_t list_q[$];
  leaf_exp_t leaf_q[$];
  list_exp_t lhead = '0;  // oldest expected list result.
  leaf_exp_t fhead = '0;

  tb_clock clk_gen0 (.clk);

  int_unit dut0 (
    .clk, .rst_n, .in_valid, .in_ray_id, .in_tri_id, .in_lindex, .in_lnum_left,
    .in_org_x(org[0]), .in_org_y(org[1]), .in_org_z(org[2]),
    .in_dir_x(dir[0]), .in_dir_y(dir[1]), .in_dir_z(dir[2]),
    .in_m00(m[0]), .in_m01(m[1]), .in_m02(m[2]),
    .in_m10(m[3]), .in_m11(m[4]), .in_m12(m[5]),
    .in_m20(m[6]), .in_m21(m[7]), .in_m22(m[8]),
    .in_tr_x(tr[0]), .in_tr_y(tr[1]), .in_tr_z(tr[2]),
    .in_credit, .list_valid, .list_ray_id, .list_tri_id, .list_hit, .list_last,
    .list_t_num, .list_denom, .list_credit,
    .leaf_valid, .leaf_ray_id, .leaf_lindex, .leaf_lnum_left, .leaf_credit
  );

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic plain_error(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic value_error(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    abort_run();
  endtask

  // identity transform and a ray straight down into the triangle.
  task automatic build_hit_geometry();
    fix_t s_mag;
    s_mag = fix_t'(128 + ($random(seed) & 255));
    for (int i = 0; i < 9; i++) m[i] = (i % 4 == 0) ? fix_t'(256) : fix_t'(0);
    for (int i = 0; i < 3; i++) tr[i] = '0;
    org[0] = fix_t'($random(seed) & 127);
    org[1] = fix_t'($random(seed) & 127);  // u + v stays below one.
    org[2] = fix_t'(256 + ($random(seed) & 511));
    dir[0] = '0;
    dir[1] = '0;
    dir[2] = -s_mag;
    if ($random(seed) % 2 == 0) begin
      org[2] = -org[2];  // ray from below makes s negative.
      dir[2] = s_mag;
    end
  endtask

  task automatic build_random_geometry();
    for (int i = 0; i < 9; i++) m[i] = fix_t'($random(seed) % 1024);
    for (int i = 0; i < 3; i++) begin
      org[i] = fix_t'($random(seed) % 1024);
      dir[i] = fix_t'($random(seed) % 1024);
      tr[i]  = fix_t'($random(seed) % 1024);
    end
  endtask

  task automatic send_request();
    logic      hit;
    logic      last;
    num_t      t_num;
    num_t      denom;
    list_exp_t le;
    leaf_exp_t fe;
    if ($random(seed) % 3 == 0) build_hit_geometry();
    else build_random_geometry();
    in_ray_id    = ray_id_w'($random(seed));
    in_tri_id    = tri_id_w'($random(seed));
    in_lindex    = lindex_w'($random(seed));
    in_lnum_left = lnum_w'($random(seed) & 3);  // short lists end often.
    intersect_ray(org, dir, m, tr, hit, t_num, denom);
    last = is_final_tri(in_lnum_left);
    le = '{in_ray_id, in_tri_id, hit, last, t_num, denom};
    fe.ray_id    = in_ray_id;
    fe.lindex    = in_lindex + 1'b1;
    fe.lnum_left = in_lnum_left - 1'b1;
    if (goes_to_list(hit, last)) list_q.push_back(le);
    if (needs_fetch(last)) leaf_q.push_back(fe);
    in_valid = 1'b1;
    started  = 1'b1;
    sent++;
  endtask

  // downstream returns one credit per item received, with random long pauses.
  task automatic return_credits(input logic pauses);
    list_credit = 1'b0;
    leaf_credit = 1'b0;
    if (list_pause > 0) list_pause--;
    else if (pauses && $random(seed) % 40 == 0) list_pause = 20 + ($random(seed) & 31);
    else list_credit = (list_seen > list_back) && ($random(seed) % 2 == 0);
    if (leaf_pause > 0) leaf_pause--;
    else if (pauses && $random(seed) % 40 == 0) leaf_pause = 20 + ($random(seed) & 31);
    else leaf_credit = (leaf_seen > leaf_back) && ($random(seed) % 2 == 0);
  endtask

  // retire delivered items and count credits.
  always @(posedge clk) begin
    if (rst_n) begin
      if (list_valid && list_q.size() > 0) void'(list_q.pop_front());
      if (leaf_valid && leaf_q.size() > 0) void'(leaf_q.pop_front());
      list_seen <= list_seen + int'(list_valid);
      leaf_seen <= leaf_seen + int'(leaf_valid);
      list_back <= list_back + int'(list_credit);
      leaf_back <= leaf_back + int'(leaf_credit);
      in_back   <= in_back + int'(in_credit);
      list_cnt  <= list_q.size();
      leaf_cnt  <= leaf_q.size();
      if (list_q.size() > 0) lhead <= list_q[0];
      if (leaf_q.size() > 0) fhead <= leaf_q[0];
    end
  end

  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> !in_credit && !list_valid && !leaf_valid)
    else plain_error("in_credit, list_valid or leaf_valid went high before any request");
  a_list_known: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_cnt > 0) else plain_error("list output with no result expected");
  a_list_ray: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_ray_id == lhead.ray_id)
    else value_error("list_ray_id", $sampled(lhead.ray_id), $sampled(list_ray_id));
  a_list_tri: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_tri_id == lhead.tri_id)
    else value_error("list_tri_id", $sampled(lhead.tri_id), $sampled(list_tri_id));
  a_list_hit: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_hit == lhead.hit)
    else value_error("list_hit", $sampled(lhead.hit), $sampled(list_hit));
  a_list_last: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_last == lhead.last)
    else value_error("list_last", $sampled(lhead.last), $sampled(list_last));
  a_list_t: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid && lhead.hit |-> list_t_num == lhead.t_num)
    else value_error("list_t_num", $sampled(lhead.t_num), $sampled(list_t_num));
  a_list_denom: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid && lhead.hit |-> list_denom == lhead.denom)
    else value_error("list_denom", $sampled(lhead.denom), $sampled(list_denom));
  a_list_route: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_hit || list_last) else plain_error("a miss that is not last reached list");
  a_leaf_known: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> leaf_cnt > 0) else plain_error("leaf output with no fetch expected");
  a_leaf_ray: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> leaf_ray_id == fhead.ray_id)
    else value_error("leaf_ray_id", $sampled(fhead.ray_id), $sampled(leaf_ray_id));
  a_leaf_index: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> leaf_lindex == fhead.lindex)
    else value_error("leaf_lindex", $sampled(fhead.lindex), $sampled(leaf_lindex));
  a_leaf_left: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> leaf_lnum_left == fhead.lnum_left)
    else value_error("leaf_lnum_left", $sampled(fhead.lnum_left), $sampled(leaf_lnum_left));
  a_list_cred: assert property (@(posedge clk) disable iff (!rst_n)
    list_valid |-> list_seen < out_credits + list_back)
    else plain_error("list_valid raised without a list credit");
  a_leaf_cred: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> leaf_seen < out_credits + leaf_back)
    else plain_error("leaf_valid raised without a leaf credit");
  a_in_cred: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit |-> in_back < sent) else plain_error("more in_credit pulses than requests sent");

  initial begin
    seed = 32'h48122cdc;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (sent < n_tests) begin
      @(negedge clk);
      in_valid = 1'b0;
      return_credits(1'b1);
      if (sent < in_credits + in_back && $random(seed) % 4 != 0) send_request();
    end
    // all credits flow back now, so both queues must empty.
    for (int c = 0; c < 2000 && (list_q.size() > 0 || leaf_q.size() > 0); c++) begin
      @(negedge clk);
      in_valid = 1'b0;
      return_credits(1'b0);
    end
    repeat (30) begin
      @(negedge clk);
      in_valid = 1'b0;
      return_credits(1'b0);
    end
    if (list_q.size() == 0 && leaf_q.size() == 0 && in_back == sent) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("results lost: %0d list, %0d leaf left, %0d of %0d input credits back",
               list_q.size(), leaf_q.size(), in_back, sent);
      abort_run();
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    plain_error($sformatf("Timeout: run did not finish within %0d cycles", wd_cycles));
  end

endmodule

//--- tb.f
+incdir+include
design/rt_pkg.sv
design/ray_intake.sv
design/int_math.sv
design/credit_fifo.sv
design/result_router.sv
design/int_unit.sv
bench/tb_clock.sv
bench/tb_int_unit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_int_unit
if ./obj_dir/Vtb_int_unit | tee /dev/stderr | grep -qx "All tests passed"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
